//--- logic/zxuno_pkg.sv
package zxuno_pkg;

   ////////////////////
   // I/O port map
   ////////////////////

   localparam logic [15:0] ZXUNOADDR_PORT = 16'hFC3B;  // Register number port
   localparam logic [15:0] ZXUNODATA_PORT = 16'hFD3B;  // Register data port

   ////////////////////
   // Register numbers
   ////////////////////

   localparam logic [7:0] REG_MASTERCONF = 8'h00;  // Config bits, bit 7 is the lock
   localparam logic [7:0] REG_FLASHSPI   = 8'h02;  // One SPI byte per access
   localparam logic [7:0] REG_FLASHCS    = 8'h03;  // Bit 0 is the flash CS level

   // Module clocks per SPI byte, two per sclk period
   localparam logic [4:0] SPI_HALF_CYCLES = 5'd16;

   ////////////////////
   // Bus structs
   ////////////////////

   // Register access, strobes last one cycle
   typedef struct packed {
      logic [7:0] num;   // Register number from the address latch
      logic       rd;    // Read of the data port
      logic       wr;    // Write of the data port
      logic [7:0] data;  // CPU write data
   } reg_req_t;

   // Answer from one register block
   typedef struct packed {
      logic [7:0] data;   // Read data
      logic       valid;  // Block owns the read
   } reg_rsp_t;

   // Serial flash outputs
   typedef struct packed {
      logic cs_n;  // Chip select, active low
      logic sclk;  // Serial clock
      logic mosi;  // Data to the flash
   } spi_pins_t;

endpackage

//--- logic/zxuno_reg_bus.sv
`timescale 1ns/1ps

module zxuno_reg_bus (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [15:0]          io_addr,   // CPU I/O address
   input  logic                 io_rd,     // One-cycle read strobe
   input  logic                 io_wr,     // One-cycle write strobe
   input  logic [7:0]           io_din,    // CPU write data
   output zxuno_pkg::reg_req_t  req,       // To all register blocks
   input  zxuno_pkg::reg_rsp_t  conf_rsp,  // From MASTERCONF
   input  zxuno_pkg::reg_rsp_t  spi_rsp,   // From the flash controller
   output logic [7:0]           io_dout,   // CPU read data
   output logic                 io_oe_n    // Low while io_dout is driven
);

   ////////////////////
   // Port decode
   ////////////////////

   logic       addr_hit;  // Access to the address port
   logic       data_hit;  // Access to the data port
   logic [7:0] reg_num;   // Current register number

   // Full 16-bit decode, as on the real machine
   assign addr_hit = (io_addr == zxuno_pkg::ZXUNOADDR_PORT);
   assign data_hit = (io_addr == zxuno_pkg::ZXUNODATA_PORT);

   ////////////////////
   // Address latch
   ////////////////////

   // Register number stays until the next address-port write
   always_ff @(posedge clk) begin
      if (reset) begin
         reg_num <= 8'h00;  // Points at MASTERCONF after reset
      end else if (addr_hit && io_wr) begin
         reg_num <= io_din;
      end
   end

   ////////////////////
   // Request strobes
   ////////////////////

   // Data-port strobes become register strobes in the same cycle
   always_comb begin
      req.num  = reg_num;
      req.rd   = data_hit && io_rd;  // Block decodes num itself
      req.wr   = data_hit && io_wr;
      req.data = io_din;             // Passed through unregistered
   end

   ////////////////////
   // Read-data merge
   ////////////////////

   // Address-port read has the latched number
   // Otherwise the one block that claims the read wins
   always_comb begin
      io_dout = 8'h00;  // Quiet bus when nothing drives
      io_oe_n = 1'b1;
      if (addr_hit && io_rd) begin
         io_dout = reg_num;
         io_oe_n = 1'b0;
      end else if (conf_rsp.valid) begin
         io_dout = conf_rsp.data;  // MASTERCONF
         io_oe_n = 1'b0;
      end else if (spi_rsp.valid) begin
         io_dout = spi_rsp.data;   // FLASHCS or FLASHSPI
         io_oe_n = 1'b0;
      end
      // Unimplemented registers leave io_oe_n high
   end

endmodule

//--- logic/master_conf.sv
`timescale 1ns/1ps

module master_conf (
   input  logic                 clk,
   input  logic                 reset,
   input  zxuno_pkg::reg_req_t  req,     // Register access from the bus decoder
   output zxuno_pkg::reg_rsp_t  rsp,     // Read answer
   output logic                 locked   // Bit 7, blocks config and flash writes
);

   logic [7:0] conf_q;  // MASTERCONF value
   logic       hit;     // Request targets MASTERCONF

   assign hit = (req.num == zxuno_pkg::REG_MASTERCONF);

   ////////////////////
   // Config register
   ////////////////////

   // Once bit 7 is set nothing gets in until reset
   always_ff @(posedge clk) begin
      if (reset) begin
         conf_q <= 8'h00;  // Lock clear
      end else if (hit && req.wr && !conf_q[7]) begin
         conf_q <= req.data;
      end
   end

   assign locked = conf_q[7];

   ////////////////////
   // Read answer
   ////////////////////

   always_comb begin
      rsp.valid = hit && req.rd;       // Reads work even when locked
      rsp.data  = conf_q;              // Merge ignores data unless valid
   end

endmodule

//--- logic/flash_spi.sv
`timescale 1ns/1ps

module flash_spi (
   input  logic                  clk,
   input  logic                  reset,
   input  zxuno_pkg::reg_req_t   req,     // Register access from the bus decoder
   input  logic                  locked,  // MASTERCONF lock, blocks writes
   output zxuno_pkg::reg_rsp_t   rsp,     // Read answer
   output zxuno_pkg::spi_pins_t  pins,    // Flash outputs
   input  logic                  miso     // Data from the flash
);

   ////////////////////
   // Register decode
   ////////////////////

   logic cs_hit;   // FLASHCS selected
   logic spi_hit;  // FLASHSPI selected
   logic spi_wr;   // Write transfer request
   logic spi_rd;   // Read transfer request

   assign cs_hit  = (req.num == zxuno_pkg::REG_FLASHCS);
   assign spi_hit = (req.num == zxuno_pkg::REG_FLASHSPI);
   assign spi_wr  = spi_hit && req.wr && !locked;  // Locked writes are dropped
   assign spi_rd  = spi_hit && req.rd;             // Reads always allowed

   ////////////////////
   // Chip select
   ////////////////////

   logic cs_q;  // Flash CS level, high is deselected

   always_ff @(posedge clk) begin
      if (reset) begin
         cs_q <= 1'b1;
      end else if (cs_hit && req.wr && !locked) begin
         cs_q <= req.data[0];
      end
   end

   ////////////////////
   // Shift engine
   ////////////////////

   logic       wr_busy;  // Write transfer running
   logic       rd_busy;  // Read transfer running
   logic [4:0] cnt;      // Half-cycle counter, bit 0 is sclk
   logic [7:0] tx_q;     // Outgoing byte, MSB on mosi
   logic [7:0] rx_q;     // Byte captured by the last read transfer
   logic       sclk;     // Flash clock, half the module clock
   logic       last;     // Final half cycle of a transfer

   assign sclk = cnt[0];
   assign last = (cnt == zxuno_pkg::SPI_HALF_CYCLES - 5'd1);

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_busy <= 1'b0;
         rd_busy <= 1'b0;
         cnt     <= 5'd0;   // sclk low
         tx_q    <= 8'h00;  // mosi low
         rx_q    <= 8'h00;
      end else if (spi_wr && !wr_busy) begin
         // New write aborts any read in progress
         wr_busy <= 1'b1;
         rd_busy <= 1'b0;
         cnt     <= 5'd0;
         tx_q    <= req.data;
      end else if (spi_rd && !rd_busy) begin
         // CPU already took rx_q this cycle, refill it
         rd_busy <= 1'b1;
         wr_busy <= 1'b0;
         cnt     <= 5'd0;
         tx_q    <= 8'h00;  // Read sends zeros
         rx_q    <= 8'h00;
      end else if (wr_busy) begin
         if (sclk) begin
            tx_q <= {tx_q[6:0], 1'b0};  // Next bit after the high phase
         end
         cnt <= cnt + 5'd1;
         if (last) begin
            wr_busy <= 1'b0;  // cnt parks at 16, sclk low
         end
      end else if (rd_busy) begin
         if (sclk) begin
            rx_q <= {rx_q[6:0], miso};  // Sample while sclk is high
         end
         cnt <= cnt + 5'd1;
         if (last) begin
            rd_busy <= 1'b0;
         end
      end
   end

   ////////////////////
   // Outputs
   ////////////////////

   always_comb begin
      pins.cs_n = cs_q;
      pins.sclk = sclk;     // Low when idle, cnt is 0 or 16
      pins.mosi = tx_q[7];  // MSB first
   end

   // FLASHCS reads the CS level, FLASHSPI the last capture
   always_comb begin
      rsp.valid = req.rd && (cs_hit || spi_hit);
      if (cs_hit) begin
         rsp.data = {7'b0000000, cs_q};
      end else begin
         rsp.data = rx_q;
      end
   end

endmodule

//--- logic/zxuno_flash_sys.sv
`timescale 1ns/1ps

module zxuno_flash_sys (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [15:0]           io_addr,     // CPU I/O address
   input  logic                  io_rd,       // One-cycle read strobe
   input  logic                  io_wr,       // One-cycle write strobe
   input  logic [7:0]            io_din,      // CPU write data
   output logic [7:0]            io_dout,     // CPU read data
   output logic                  io_oe_n,     // Low while io_dout is valid
   output zxuno_pkg::spi_pins_t  flash_pins,  // To the serial flash
   input  logic                  flash_miso   // From the serial flash
);

   ////////////////////
   // Internal wires
   ////////////////////

   zxuno_pkg::reg_req_t req;       // Shared register request
   zxuno_pkg::reg_rsp_t conf_rsp;  // MASTERCONF answer
   zxuno_pkg::reg_rsp_t spi_rsp;   // Flash register answer
   logic                locked;    // Config lock into the flash block

   // Address latch, strobe decode, read merge
   zxuno_reg_bus i_reg_bus (
      .clk      (clk),
      .reset    (reset),
      .io_addr  (io_addr),
      .io_rd    (io_rd),
      .io_wr    (io_wr),
      .io_din   (io_din),
      .req      (req),
      .conf_rsp (conf_rsp),
      .spi_rsp  (spi_rsp),
      .io_dout  (io_dout),
      .io_oe_n  (io_oe_n)
   );

   // MASTERCONF, source of the lock
   master_conf i_master_conf (
      .clk    (clk),
      .reset  (reset),
      .req    (req),
      .rsp    (conf_rsp),
      .locked (locked)
   );

   // FLASHCS and FLASHSPI
   flash_spi i_flash_spi (
      .clk    (clk),
      .reset  (reset),
      .req    (req),
      .locked (locked),
      .rsp    (spi_rsp),
      .pins   (flash_pins),
      .miso   (flash_miso)
   );

endmodule

//--- sim/spi_flash_model.sv
`timescale 1ns/1ps

module spi_flash_model (
   input  logic cs_n,  // Chip select, active low
   input  logic sclk,  // Serial clock from the controller
   input  logic mosi,  // Data into the flash
   output logic miso   // Data out of the flash
);

   logic [7:0] last_rx = 8'hA5;  // Byte to echo next
   logic [7:0] in_sr   = 8'h00;  // Incoming shift register
   logic [7:0] out_sr  = 8'hA5;  // Outgoing shift register
   logic [3:0] bits    = 4'd0;   // Bits received in the current byte
   logic       miso_q  = 1'b1;   // Bit on the wire while selected
   logic       cs_n_q  = 1'b1;   // Previous cs_n, for edge detection
   logic       sclk_q  = 1'b0;   // Previous sclk

   ////////////////////
   // SPI mode 0 slave
   ////////////////////

   always @(cs_n or sclk) begin
      if (cs_n_q && !cs_n) begin
         // Selected, first bit shows before the first rising sclk
         out_sr = last_rx;
         miso_q = last_rx[7];
         bits   = 4'd0;
      end else if (!cs_n && sclk && !sclk_q) begin
         in_sr = {in_sr[6:0], mosi};  // Sample on rising sclk
         bits  = bits + 4'd1;
         if (bits == 4'd8) begin
            last_rx = in_sr;          // Whole byte in
            bits    = 4'd0;
         end
      end else if (!cs_n && !sclk && sclk_q) begin
         if (bits == 4'd0) begin
            out_sr = last_rx;         // Next byte echoes the one just received
         end else begin
            out_sr = {out_sr[6:0], 1'b0};
         end
         miso_q = out_sr[7];          // Shift out on falling sclk
      end
      cs_n_q = cs_n;
      sclk_q = sclk;
   end

   // Pulled high while not selected
   assign miso = (cs_n === 1'b0) ? miso_q : 1'b1;

endmodule

//--- sim/tb_zxuno_flash.sv
`timescale 1ns/1ps

module tb_zxuno_flash;

   logic                 clk;
   logic                 reset;
   logic [15:0]          io_addr;
   logic                 io_rd;
   logic                 io_wr;
   logic [7:0]           io_din;
   logic [7:0]           io_dout;
   logic                 io_oe_n;
   zxuno_pkg::spi_pins_t flash_pins;
   logic                 flash_miso;
   logic                 flash_sclk;

   // Reference model state
   logic [7:0] m_num;    // Latched register number
   logic [7:0] m_conf;   // MASTERCONF with the lock in bit 7
   logic       m_cs_n;   // Flash chip select level
   logic [7:0] m_flash;  // Last byte the flash received
   logic [7:0] m_capt;   // Byte from the last read transfer

   int          errors     = 0;
   int          checks     = 0;
   int          sclk_rises = 0;         // Rising sclk edges seen so far
   logic [7:0]  mosi_bits  = 8'h00;     // Last eight mosi bits at rising sclk
   logic [31:0] lcg_state  = 32'd55390;

   zxuno_flash_sys i_dut (
      .clk        (clk),
      .reset      (reset),
      .io_addr    (io_addr),
      .io_rd      (io_rd),
      .io_wr      (io_wr),
      .io_din     (io_din),
      .io_dout    (io_dout),
      .io_oe_n    (io_oe_n),
      .flash_pins (flash_pins),
      .flash_miso (flash_miso)
   );

   spi_flash_model i_flash (
      .cs_n (flash_pins.cs_n),
      .sclk (flash_pins.sclk),
      .mosi (flash_pins.mosi),
      .miso (flash_miso)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;  // 10 ns period
   end

   assign flash_sclk = flash_pins.sclk;

   // mosi is stable at rising sclk
   always @(posedge flash_sclk) begin
      sclk_rises = sclk_rises + 1;
      mosi_bits  = {mosi_bits[6:0], flash_pins.mosi};
   end

   ////////////////////
   // Helpers
   ////////////////////

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return {16'h0000, lcg_state[31:16]};  // Upper half only since the low bits are weak
   endfunction

   task automatic check(input string name, input logic [7:0] expected,
                        input logic [7:0] actual);
      checks = checks + 1;
      if (actual !== expected) begin
         errors = errors + 1;
         $display("error: %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   // Bounded wait for a number of rising sclk edges
   task automatic wait_rises(input int target, input int limit);
      int n;
      n = 0;
      while (sclk_rises < target && n < limit) begin
         @(negedge clk);
         n = n + 1;
      end
      if (sclk_rises < target) begin
         errors = errors + 1;
         $display("timeout: sclk still short of %0d rising edges after %0d cycles",
                  target, limit);
      end
   endtask

   task automatic apply_reset();
      @(negedge clk);
      reset = 1'b1;
      repeat (4) @(negedge clk);
      reset  = 1'b0;
      m_num  = 8'h00;
      m_conf = 8'h00;
      m_cs_n = 1'b1;
      m_capt = 8'h00;  // Flash keeps its own byte across a DUT reset
   endtask

   // One-cycle write strobe with inputs changed on falling edges
   task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
      @(negedge clk);
      io_addr = addr;
      io_din  = data;
      io_wr   = 1'b1;
      @(negedge clk);
      io_wr   = 1'b0;
   endtask

   // Reads are combinational so sample mid low phase
   task automatic bus_read(input logic [15:0] addr, output logic [7:0] data,
                           output logic oe_n);
      @(negedge clk);
      io_addr = addr;
      io_rd   = 1'b1;
      #2;
      data = io_dout;
      oe_n = io_oe_n;
      @(negedge clk);
      io_rd = 1'b0;
   endtask

   task automatic select_reg(input logic [7:0] num);
      bus_write(zxuno_pkg::ZXUNOADDR_PORT, num);
      m_num = num;
   endtask

   task automatic read_addr(input string name);
      logic [7:0] data;
      logic       oe_n;
      bus_read(zxuno_pkg::ZXUNOADDR_PORT, data, oe_n);
      check($sformatf("%s oe_n", name), 8'h00, {7'd0, oe_n});
      check(name, m_num, data);
   endtask

   ////////////////////
   // Data port
   ////////////////////

   task automatic write_data(input logic [7:0] data);
      int start;
      start = sclk_rises;
      bus_write(zxuno_pkg::ZXUNODATA_PORT, data);
      case (m_num)
         zxuno_pkg::REG_MASTERCONF: begin
            if (!m_conf[7]) begin
               m_conf = data;  // Frozen once bit 7 is set
            end
         end
         zxuno_pkg::REG_FLASHCS: begin
            if (!m_conf[7]) begin
               m_cs_n = data[0];
            end
            check("cs_n after write", {7'd0, m_cs_n}, {7'd0, flash_pins.cs_n});
         end
         zxuno_pkg::REG_FLASHSPI: begin
            if (m_conf[7]) begin
               idle(20);  // No transfer may start
               check("sclk rises while locked", 8'd0, 8'(sclk_rises - start));
            end else begin
               wait_rises(start + 8, 40);
               idle(4);   // Let the last half cycle finish
               check("sclk rises on write", 8'd8, 8'(sclk_rises - start));
               check("mosi byte", data, mosi_bits);
               if (!m_cs_n) begin
                  m_flash = data;
               end
            end
         end
         default: begin
         end
      endcase
   endtask

   task automatic read_data(input string name, output logic [7:0] got);
      logic [7:0] data;
      logic       oe_n;
      logic [7:0] exp_data;
      logic       exp_oe_n;
      int         start;
      start = sclk_rises;
      bus_read(zxuno_pkg::ZXUNODATA_PORT, data, oe_n);
      got      = data;
      exp_oe_n = 1'b0;
      exp_data = 8'h00;
      case (m_num)
         zxuno_pkg::REG_MASTERCONF: exp_data = m_conf;
         zxuno_pkg::REG_FLASHCS:    exp_data = {7'd0, m_cs_n};
         zxuno_pkg::REG_FLASHSPI:   exp_data = m_capt;
         default:                   exp_oe_n = 1'b1;  // Nobody drives the bus
      endcase
      check($sformatf("%s oe_n", name), {7'd0, exp_oe_n}, {7'd0, oe_n});
      if (!exp_oe_n) begin
         check(name, exp_data, data);
      end
      if (m_num == zxuno_pkg::REG_FLASHSPI) begin
         // Read hands over the old capture and starts a new one
         wait_rises(start + 8, 40);
         idle(4);
         check("sclk rises on read", 8'd8, 8'(sclk_rises - start));
         check("mosi zeros on read", 8'h00, mosi_bits);
         if (!m_cs_n) begin
            m_capt  = m_flash;  // Echo of the previous byte
            m_flash = 8'h00;    // Flash just received zeros
         end else begin
            m_capt = 8'hFF;     // Deselected flash pulls miso high
         end
      end
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin : main_seq
      logic [31:0] r;
      logic [31:0] d;
      logic [7:0]  got;
      logic [7:0]  b;
      logic [7:0]  conf_val;
      int          lock_at;
      io_addr = 16'h0000;
      io_rd   = 1'b0;
      io_wr   = 1'b0;
      io_din  = 8'h00;
      reset   = 1'b1;
      m_flash = 8'hA5;  // Power-up byte of the flash
      apply_reset();

      // Address port round trip and an unimplemented register
      r = next_rand();
      select_reg(r[7:0]);
      read_addr("address round trip");
      r = next_rand();
      select_reg(r[7:0] | 8'h10);
      read_data("unimplemented read", got);

      // MASTERCONF storage with the lock clear
      select_reg(zxuno_pkg::REG_MASTERCONF);
      r = next_rand();
      write_data({1'b0, r[6:0]});
      read_data("masterconf read", got);

      // Chip select level and read back
      select_reg(zxuno_pkg::REG_FLASHCS);
      r = next_rand();
      write_data(r[7:0]);
      read_data("flashcs read", got);
      write_data(8'h00);  // Select the flash

      // Write a byte, then read its echo back
      select_reg(zxuno_pkg::REG_FLASHSPI);
      r = next_rand();
      b = r[7:0];
      write_data(b);
      read_data("first flashspi read", got);
      check("capture after reset", 8'h00, got);
      read_data("second flashspi read", got);
      check("flash echo", b, got);

      // Lock freezes config and flash writes
      select_reg(zxuno_pkg::REG_MASTERCONF);
      r = next_rand();
      write_data({1'b1, r[6:0]});
      conf_val = m_conf;
      write_data(~conf_val);  // Every bit differs from the locked value
      read_data("masterconf after lock", got);
      check("masterconf frozen", conf_val, got);
      select_reg(zxuno_pkg::REG_FLASHCS);
      write_data({7'd0, ~m_cs_n});  // cs_n must stay put
      select_reg(zxuno_pkg::REG_FLASHSPI);
      r = next_rand();
      write_data(r[7:0]);
      read_data("flashspi read while locked", got);

      // Random mix from a fresh reset
      apply_reset();
      r = next_rand();
      lock_at = 100 + int'(r[7:0]);
      for (int i = 0; i < 400; i++) begin
         r = next_rand();
         d = next_rand();
         if (i == lock_at) begin
            select_reg(zxuno_pkg::REG_MASTERCONF);
            write_data({1'b1, d[6:0]});  // Lock goes on once
         end else begin
            case (r[2:0])
               3'd0: begin
                  case (r[9:8])
                     2'd0:    select_reg(zxuno_pkg::REG_MASTERCONF);
                     2'd1:    select_reg(zxuno_pkg::REG_FLASHSPI);
                     2'd2:    select_reg(zxuno_pkg::REG_FLASHCS);
                     default: select_reg(d[7:0]);
                  endcase
               end
               3'd1: read_addr("random address read");
               3'd2, 3'd3: begin
                  if (m_num == zxuno_pkg::REG_MASTERCONF && !m_conf[7]) begin
                     write_data({1'b0, d[6:0]});  // Lock only at lock_at
                  end else begin
                     write_data(d[7:0]);
                  end
               end
               3'd4, 3'd5, 3'd6: read_data("random data read", got);
               default: idle(int'(r[4:3]) + 1);
            endcase
         end
      end

      $display("errors %0d checks %0d", errors, checks);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- zxuno_flash.f
logic/zxuno_pkg.sv
logic/zxuno_reg_bus.sv
logic/master_conf.sv
logic/flash_spi.sv
logic/zxuno_flash_sys.sv
sim/spi_flash_model.sv
sim/tb_zxuno_flash.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   --top-module tb_zxuno_flash \
   -f zxuno_flash.f \
   -o tb_zxuno_flash

./obj_dir/tb_zxuno_flash > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation finished cleanly"
